// ==== rvfi_chk_pkg.sv ====
package rvfi_chk_pkg;

  //////////////////////////////////////////////////////////////////////
  // Basic widths
  //////////////////////////////////////////////////////////////////////

  // Data or address word on the bus and on RVFI
  typedef logic [31:0] word_t;
  // Byte enable on OBI, byte mask on RVFI
  typedef logic [3:0]  be_t;
  // OBI protection attribute
  typedef logic [2:0]  prot_t;
  // Exception cause as reported in rvfi_trap
  typedef logic [5:0]  exc_cause_t;

  //////////////////////////////////////////////////////////////////////
  // Bus and retirement records
  //////////////////////////////////////////////////////////////////////

  // One granted OBI data request
  typedef struct packed {
    word_t addr;
    be_t   be;
    logic  we;
    word_t wdata;
    prot_t prot;
  } obi_req_t;

  // One OBI data response, in request order
  typedef struct packed {
    word_t rdata;
    logic  err;
  } obi_resp_t;

  // Memory part of one RVFI retirement, exactly one operation
  typedef struct packed {
    word_t addr;
    be_t   rmask;
    be_t   wmask;
    word_t rdata;
    word_t wdata;
    prot_t prot;
  } rvfi_mem_t;

  typedef struct packed {
    logic       trap;
    logic       exception;
    exc_cause_t exception_cause;
  } rvfi_trap_t;

  // Verdict flags, intr_err sits in the lowest bit
  typedef struct packed {
    logic addr_err;
    logic mask_err;
    logic data_err;
    logic prot_err;
    logic missing_err;
    logic intr_err;
  } chk_err_t;

  // Load/store causes whose data is not compared
  localparam exc_cause_t EXC_LOAD_MISALIGNED  = 6'd4;
  localparam exc_cause_t EXC_LOAD_FAULT       = 6'd5;
  localparam exc_cause_t EXC_STORE_MISALIGNED = 6'd6;
  localparam exc_cause_t EXC_STORE_FAULT      = 6'd7;

  // Expands a byte mask into a bit mask over one word
  function automatic word_t be_to_bitmask(be_t be);
    word_t mask;
    for (int i = 0; i < 4; i++) begin
      mask[8*i +: 8] = {8{be[i]}};
    end
    return mask;
  endfunction

endpackage

// ==== obi_xfer_fifo.sv ====
`timescale 1ns/1ps

module obi_xfer_fifo #(
  parameter int unsigned FIFO_DEPTH = 8,
  parameter type         entry_t    = logic [31:0],
  localparam int unsigned PTR_W     = $clog2(FIFO_DEPTH),
  localparam int unsigned CNT_W     = $clog2(FIFO_DEPTH) + 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  entry_t           push_data_i,
  input  logic [1:0]       pop_cnt_i,
  output entry_t           head_o,
  output entry_t           head_next_o,
  output logic [CNT_W-1:0] count_o
);

  // Captured entries in arrival order
  entry_t mem_q [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] rd_ptr_inc;
  logic [CNT_W-1:0] count_q;
  logic             push_ok;

  // A push into a full buffer is lost because the checker cannot stall the core
  assign push_ok    = push_i && (count_q != CNT_W'(FIFO_DEPTH));
  assign rd_ptr_inc = rd_ptr_q + PTR_W'(1);

  // Second entry is needed for the upper half of a split access
  assign head_o      = mem_q[rd_ptr_q];
  assign head_next_o = mem_q[rd_ptr_inc];
  assign count_o     = count_q;

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      // Pointers wrap naturally since the depth is a power of two
      rd_ptr_q <= rd_ptr_q + PTR_W'(pop_cnt_i);
      count_q  <= count_q + CNT_W'(push_ok) - CNT_W'(pop_cnt_i);
    end
  end

  // Bus traffic outran the retirements that consume it
  a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (count_q != CNT_W'(FIFO_DEPTH)));

  // The controller only pops transfers that are already stored
  a_pop_within_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    CNT_W'(pop_cnt_i) <= count_q);

endmodule

// ==== rvfi_mem_expect.sv ====
`timescale 1ns/1ps

module rvfi_mem_expect (
  input  rvfi_chk_pkg::obi_req_t  req_head_i,
  input  rvfi_chk_pkg::obi_req_t  req_next_i,
  input  rvfi_chk_pkg::obi_resp_t resp_head_i,
  input  rvfi_chk_pkg::obi_resp_t resp_next_i,
  input  logic                    split_i,
  input  logic                    is_read_i,
  output rvfi_chk_pkg::rvfi_mem_t exp_o
);

  import rvfi_chk_pkg::*;

  // Byte offset of the access inside the first bus word
  logic [1:0] offset;
  // Byte position where the second transfer continues on RVFI
  logic [2:0] shift_2nd;
  be_t        exp_mask;

  // Each transfer's data reduced to its enabled bytes
  word_t      wdata_1st;
  word_t      wdata_2nd;
  word_t      rdata_1st;
  word_t      rdata_2nd;

  assign offset    = req_head_i.addr[1:0];
  assign shift_2nd = 3'd4 - {1'b0, offset};

  assign wdata_1st = req_head_i.wdata & be_to_bitmask(req_head_i.be);
  assign wdata_2nd = req_next_i.wdata & be_to_bitmask(req_next_i.be);
  assign rdata_1st = resp_head_i.rdata & be_to_bitmask(req_head_i.be);
  assign rdata_2nd = resp_next_i.rdata & be_to_bitmask(req_next_i.be);

  //////////////////////////////////////////////////////////////////////
  // Mask and data alignment
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (split_i) begin
      // Lower bytes come from the first word, shifted down to bit 0
      // Upper bytes come from the next word, placed above them
      exp_mask    = (req_head_i.be >> offset) | (req_next_i.be << shift_2nd);
      exp_o.wdata = (wdata_1st >> {offset, 3'b000}) | (wdata_2nd << {shift_2nd, 3'b000});
      exp_o.rdata = (rdata_1st >> {offset, 3'b000}) | (rdata_2nd << {shift_2nd, 3'b000});
    end else begin
      // A single transfer is just realigned to the LSB side of RVFI
      exp_mask    = req_head_i.be >> offset;
      exp_o.wdata = req_head_i.wdata >> {offset, 3'b000};
      exp_o.rdata = resp_head_i.rdata >> {offset, 3'b000};
    end

    // Both halves of a split carry the same prot, the first address is reported
    exp_o.addr = req_head_i.addr;
    exp_o.prot = req_head_i.prot;

    // Only one of the masks is populated
    if (is_read_i) begin
      exp_o.rmask = exp_mask;
      exp_o.wmask = '0;
    end else begin
      exp_o.rmask = '0;
      exp_o.wmask = exp_mask;
    end
  end

endmodule

// ==== rvfi_mem_compare.sv ====
`timescale 1ns/1ps

module rvfi_mem_compare (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    check_en_i,
  input  logic                    data_check_en_i,
  input  logic                    missing_i,
  input  rvfi_chk_pkg::rvfi_mem_t exp_i,
  input  rvfi_chk_pkg::rvfi_mem_t act_i,
  output logic                    mem_err_valid_o,
  output logic [4:0]              mem_err_o
);

  import rvfi_chk_pkg::*;

  logic       is_access;
  logic       fields_en;
  logic [4:0] mem_err_d;
  word_t      rdata_diff;
  word_t      wdata_diff;

  // A retirement with empty masks carries no memory operation
  assign is_access = (|act_i.rmask) || (|act_i.wmask);
  // Without stored transfers the expected record is meaningless
  assign fields_en = check_en_i && is_access && !missing_i;

  // Only bytes reported on RVFI take part in the data check
  assign rdata_diff = (exp_i.rdata ^ act_i.rdata) & be_to_bitmask(act_i.rmask);
  assign wdata_diff = (exp_i.wdata ^ act_i.wdata) & be_to_bitmask(act_i.wmask);

  // Order follows chk_err_t from addr_err down to missing_err
  assign mem_err_d[4] = fields_en && (exp_i.addr != act_i.addr);
  assign mem_err_d[3] = fields_en && ((exp_i.rmask != act_i.rmask) ||
                                      (exp_i.wmask != act_i.wmask));
  assign mem_err_d[2] = data_check_en_i && ((|rdata_diff) || (|wdata_diff));
  assign mem_err_d[1] = fields_en && (exp_i.prot != act_i.prot);
  assign mem_err_d[0] = check_en_i && missing_i;

  // Verdict is held for exactly one cycle after the retirement
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_err_valid_o <= 1'b0;
      mem_err_o       <= '0;
    end else begin
      mem_err_valid_o <= check_en_i;
      mem_err_o       <= check_en_i ? mem_err_d : 5'b0;
    end
  end

  // The controller never asks for data on a retirement it cannot match
  a_data_needs_transfers: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_check_en_i |-> (check_en_i && !missing_i));

endmodule

// ==== irq_ack_tracker.sv ====
`timescale 1ns/1ps

module irq_ack_tracker (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic irq_ack_i,
  input  logic rvfi_valid_i,
  input  logic rvfi_intr_i,
  output logic intr_err_o
);

  // Set by an acknowledge, consumed by the next retirement
  logic pending_q;
  logic pending_d;
  logic intr_err_d;

  // The retirement in the ack cycle still belongs to the old handler state
  assign intr_err_d = rvfi_valid_i && pending_q && !rvfi_intr_i;

  always_comb begin
    pending_d = pending_q;
    if (irq_ack_i) begin
      pending_d = 1'b1;
    end else if (rvfi_valid_i) begin
      pending_d = 1'b0;
    end
  end

  // Flag lines up with the memory verdict of the same retirement
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q  <= 1'b0;
      intr_err_o <= 1'b0;
    end else begin
      pending_q  <= pending_d;
      intr_err_o <= intr_err_d;
    end
  end

endmodule

// ==== rvfi_chk_ctrl.sv ====
`timescale 1ns/1ps

module rvfi_chk_ctrl #(
  parameter int unsigned  FIFO_DEPTH = 8,
  localparam int unsigned CNT_W      = $clog2(FIFO_DEPTH) + 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rvfi_valid_i,
  input  rvfi_chk_pkg::rvfi_mem_t  rvfi_mem_i,
  input  rvfi_chk_pkg::rvfi_trap_t rvfi_trap_i,
  input  logic [CNT_W-1:0]         req_count_i,
  input  logic [CNT_W-1:0]         resp_count_i,
  output logic [1:0]               pop_cnt_o,
  output logic                     split_o,
  output logic                     is_read_o,
  output logic                     check_en_o,
  output logic                     data_check_en_o,
  output logic                     missing_o
);

  import rvfi_chk_pkg::*;

  be_t        acc_mask;
  logic [2:0] mask_ones;
  logic [1:0] need_cnt;
  logic       mem_ret;
  logic       enough;
  logic       blocked;

  //////////////////////////////////////////////////////////////////////
  // Classification of the retirement
  //////////////////////////////////////////////////////////////////////

  assign acc_mask  = rvfi_mem_i.rmask | rvfi_mem_i.wmask;
  assign mask_ones = 3'(acc_mask[0]) + 3'(acc_mask[1]) + 3'(acc_mask[2]) + 3'(acc_mask[3]);
  assign is_read_o = |rvfi_mem_i.rmask;
  assign mem_ret   = rvfi_valid_i && (|acc_mask);

  // Access crosses into the next word when offset plus size passes 4 bytes
  assign split_o  = ({1'b0, rvfi_mem_i.addr[1:0]} + mask_ones) > 3'd4;
  assign need_cnt = split_o ? 2'd2 : 2'd1;

  // Both the request and its response must already be stored
  assign enough = (req_count_i >= CNT_W'(need_cnt)) && (resp_count_i >= CNT_W'(need_cnt));

  // Faulting loads and stores keep their transfers but report no valid data
  assign blocked = rvfi_trap_i.trap && rvfi_trap_i.exception &&
                   ((rvfi_trap_i.exception_cause == EXC_LOAD_MISALIGNED)  ||
                    (rvfi_trap_i.exception_cause == EXC_LOAD_FAULT)       ||
                    (rvfi_trap_i.exception_cause == EXC_STORE_MISALIGNED) ||
                    (rvfi_trap_i.exception_cause == EXC_STORE_FAULT));

  //////////////////////////////////////////////////////////////////////
  // Decisions
  //////////////////////////////////////////////////////////////////////

  // Every retirement yields a verdict, even one without a memory access
  assign check_en_o      = rvfi_valid_i;
  assign missing_o       = mem_ret && !enough;
  assign data_check_en_o = mem_ret && enough && !blocked;

  // Nothing is consumed when transfers are missing, so later checks stay aligned
  assign pop_cnt_o = (mem_ret && enough) ? need_cnt : 2'd0;

  // One operation per retirement, so a load and a store never retire together
  a_single_direction: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_i |-> !((|rvfi_mem_i.rmask) && (|rvfi_mem_i.wmask)));

endmodule

// ==== rvfi_mem_checker.sv ====
`timescale 1ns/1ps

module rvfi_mem_checker #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // OBI data request channel
  input  logic                     data_req_i,
  input  logic                     data_gnt_i,
  input  rvfi_chk_pkg::obi_req_t   data_req_payload_i,
  // OBI data response channel
  input  logic                     data_rvalid_i,
  input  rvfi_chk_pkg::obi_resp_t  data_resp_payload_i,
  // Retirement
  input  logic                     rvfi_valid_i,
  input  rvfi_chk_pkg::rvfi_mem_t  rvfi_mem_i,
  input  rvfi_chk_pkg::rvfi_trap_t rvfi_trap_i,
  input  logic                     rvfi_intr_i,
  input  logic                     irq_ack_i,
  // Verdict
  output logic                     err_valid_o,
  output rvfi_chk_pkg::chk_err_t   err_o
);

  import rvfi_chk_pkg::*;

  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH) + 1;

  obi_req_t         req_head;
  obi_req_t         req_next;
  obi_resp_t        resp_head;
  obi_resp_t        resp_next;
  logic [CNT_W-1:0] req_count;
  logic [CNT_W-1:0] resp_count;
  logic [1:0]       pop_cnt;
  logic             req_push;
  logic             split;
  logic             is_read;
  logic             check_en;
  logic             data_check_en;
  logic             missing;
  rvfi_mem_t        exp_mem;
  logic [4:0]       mem_err;
  logic             intr_err;

  // A request counts only in its address phase handshake
  assign req_push = data_req_i && data_gnt_i;

  obi_xfer_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .entry_t(obi_req_t)) u_req_fifo (
    .clk_i, .rst_ni, .push_i(req_push), .push_data_i(data_req_payload_i),
    .pop_cnt_i(pop_cnt), .head_o(req_head), .head_next_o(req_next), .count_o(req_count));

  obi_xfer_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .entry_t(obi_resp_t)) u_resp_fifo (
    .clk_i, .rst_ni, .push_i(data_rvalid_i), .push_data_i(data_resp_payload_i),
    .pop_cnt_i(pop_cnt), .head_o(resp_head), .head_next_o(resp_next), .count_o(resp_count));

  rvfi_chk_ctrl #(.FIFO_DEPTH(FIFO_DEPTH)) u_ctrl (
    .clk_i, .rst_ni, .rvfi_valid_i, .rvfi_mem_i, .rvfi_trap_i,
    .req_count_i(req_count), .resp_count_i(resp_count), .pop_cnt_o(pop_cnt),
    .split_o(split), .is_read_o(is_read), .check_en_o(check_en),
    .data_check_en_o(data_check_en), .missing_o(missing));

  rvfi_mem_expect u_expect (
    .req_head_i(req_head), .req_next_i(req_next), .resp_head_i(resp_head),
    .resp_next_i(resp_next), .split_i(split), .is_read_i(is_read), .exp_o(exp_mem));

  rvfi_mem_compare u_compare (
    .clk_i, .rst_ni, .check_en_i(check_en), .data_check_en_i(data_check_en),
    .missing_i(missing), .exp_i(exp_mem), .act_i(rvfi_mem_i),
    .mem_err_valid_o(err_valid_o), .mem_err_o(mem_err));

  irq_ack_tracker u_irq_tracker (
    .clk_i, .rst_ni, .irq_ack_i, .rvfi_valid_i, .rvfi_intr_i, .intr_err_o(intr_err));

  // Memory flags fill the upper fields, the interrupt flag the lowest one
  assign err_o = {mem_err, intr_err};

endmodule

// ==== tb_rvfi_mem_checker.sv ====
`timescale 1ns/1ps

module tb_rvfi_mem_checker;

  import rvfi_chk_pkg::*;

  localparam int unsigned NUM_TESTS      = 23;
  localparam int unsigned WORDS_PER_TEST = 22;
  localparam int unsigned NUM_WORDS      = NUM_TESTS * WORDS_PER_TEST;
  // Longest test needs nine cycles and twelve leave some slack
  localparam int unsigned TIMEOUT_CYCLES = NUM_TESTS * 12 + 20;

  // One bus transfer whose data is the write data of a store or the read data of a load
  typedef struct packed {
    word_t addr;
    be_t   be;
    logic  we;
    word_t data;
    prot_t prot;
  } xfer_t;

  // One line of the stimulus file
  typedef struct packed {
    logic [7:0] code;
    logic [1:0] n_xfer;
    xfer_t      xfer0;
    xfer_t      xfer1;
    rvfi_mem_t  mem;
    rvfi_trap_t trap;
    logic       irq_ack;
    logic       intr;
    chk_err_t   exp_err;
  } test_vec_t;

  logic       clk_i;
  logic       rst_ni;
  logic       data_req_i;
  logic       data_gnt_i;
  obi_req_t   data_req_payload_i;
  logic       data_rvalid_i;
  obi_resp_t  data_resp_payload_i;
  logic       rvfi_valid_i;
  rvfi_mem_t  rvfi_mem_i;
  rvfi_trap_t rvfi_trap_i;
  logic       rvfi_intr_i;
  logic       irq_ack_i;
  logic       err_valid_o;
  chk_err_t   err_o;

  logic [31:0] vec_mem [NUM_WORDS];
  logic        load_err;
  int unsigned pass_cnt;
  int unsigned fail_cnt;
  int unsigned cycle_cnt;

  rvfi_mem_checker #(.FIFO_DEPTH(8)) u_rvfi_mem_checker (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Ends a run that got stuck somewhere in the test sequence
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles before all tests were done", cycle_cnt);
    $display("TESTBENCH FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus file decoding
  //////////////////////////////////////////////////////////////////////

  function automatic xfer_t fetch_xfer(input int unsigned base);
    xfer_t xfer;
    xfer.addr = vec_mem[base];
    xfer.be   = vec_mem[base+1][3:0];
    xfer.we   = vec_mem[base+2][0];
    xfer.data = vec_mem[base+3];
    xfer.prot = vec_mem[base+4][2:0];
    return xfer;
  endfunction

  // Word order follows the column legend at the top of the file
  function automatic test_vec_t fetch_test(input int unsigned idx);
    test_vec_t   vec;
    int unsigned base;
    base          = idx * WORDS_PER_TEST;
    vec.code      = vec_mem[base][7:0];
    vec.n_xfer    = vec_mem[base+1][1:0];
    vec.xfer0     = fetch_xfer(base + 2);
    vec.xfer1     = fetch_xfer(base + 7);
    vec.mem.addr  = vec_mem[base+12];
    vec.mem.rmask = vec_mem[base+13][3:0];
    vec.mem.wmask = vec_mem[base+14][3:0];
    vec.mem.rdata = vec_mem[base+15];
    vec.mem.wdata = vec_mem[base+16];
    vec.mem.prot  = vec_mem[base+17][2:0];
    vec.trap      = vec_mem[base+18][7:0];
    vec.irq_ack   = vec_mem[base+19][0];
    vec.intr      = vec_mem[base+20][0];
    vec.exp_err   = vec_mem[base+21][5:0];
    return vec;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus and retirement drivers
  //////////////////////////////////////////////////////////////////////

  // Called right after a rising edge and returns after the response cycle
  task automatic drive_xfer(input xfer_t xfer);
    obi_req_t  req;
    obi_resp_t resp;
    req.addr   = xfer.addr;
    req.be     = xfer.be;
    req.we     = xfer.we;
    req.wdata  = xfer.we ? xfer.data : '0;
    req.prot   = xfer.prot;
    resp.rdata = xfer.we ? '0 : xfer.data;
    resp.err   = 1'b0;
    data_req_i         <= 1'b1;
    data_gnt_i         <= 1'b1;
    data_req_payload_i <= req;
    @(posedge clk_i);
    data_req_i          <= 1'b0;
    data_gnt_i          <= 1'b0;
    data_req_payload_i  <= '0;
    data_rvalid_i       <= 1'b1;
    data_resp_payload_i <= resp;
    @(posedge clk_i);
    data_rvalid_i       <= 1'b0;
    data_resp_payload_i <= '0;
  endtask

  task automatic record_result(input string name, input logic test_ok);
    if (test_ok) begin
      pass_cnt++;
      $display("test %s passed", name);
    end else begin
      fail_cnt++;
      $display("test %s failed", name);
    end
  endtask

  task automatic check_reset_state();
    @(negedge clk_i);
    if ((err_valid_o !== 1'b0) || (err_o !== '0)) begin
      $display("error reset: err_valid_o %0h err_o %02h, expected 0 and 00", err_valid_o, err_o);
      record_result("reset", 1'b0);
    end else begin
      record_result("reset", 1'b1);
    end
  endtask

  task automatic run_test(input test_vec_t vec);
    logic test_ok;
    test_ok = 1'b1;
    // The acknowledge comes one cycle ahead of the transfers
    @(posedge clk_i);
    irq_ack_i <= vec.irq_ack;
    @(posedge clk_i);
    irq_ack_i <= 1'b0;
    if (vec.n_xfer > 2'd0) begin
      drive_xfer(vec.xfer0);
    end
    if (vec.n_xfer > 2'd1) begin
      drive_xfer(vec.xfer1);
    end
    // Retirement starts in the cycle after the last response
    rvfi_valid_i <= 1'b1;
    rvfi_mem_i   <= vec.mem;
    rvfi_trap_i  <= vec.trap;
    rvfi_intr_i  <= vec.intr;
    @(posedge clk_i);
    rvfi_valid_i <= 1'b0;
    rvfi_mem_i   <= '0;
    rvfi_trap_i  <= '0;
    rvfi_intr_i  <= 1'b0;
    // The verdict belongs to the cycle right after the retirement
    @(negedge clk_i);
    if (err_valid_o !== 1'b1) begin
      $display("error test %02h: err_valid_o got %0h expected 1", vec.code, err_valid_o);
      test_ok = 1'b0;
    end else if (err_o !== vec.exp_err) begin
      $display("error test %02h: err_o got %02h expected %02h", vec.code, err_o, vec.exp_err);
      test_ok = 1'b0;
    end
    // Verdict is a single cycle pulse
    @(negedge clk_i);
    if (err_valid_o !== 1'b0) begin
      $display("test %02h: err_valid_o stayed high for more than one cycle", vec.code);
      test_ok = 1'b0;
    end
    record_result($sformatf("%02h", vec.code), test_ok);
  endtask

  initial begin
    rst_ni              = 1'b0;
    data_req_i          = 1'b0;
    data_gnt_i          = 1'b0;
    data_req_payload_i  = '0;
    data_rvalid_i       = 1'b0;
    data_resp_payload_i = '0;
    rvfi_valid_i        = 1'b0;
    rvfi_mem_i          = '0;
    rvfi_trap_i         = '0;
    rvfi_intr_i         = 1'b0;
    irq_ack_i           = 1'b0;
    pass_cnt            = 0;
    fail_cnt            = 0;
    load_err            = 1'b0;
    $readmemh("rvfi_stim_input.txt", vec_mem);
    if ($isunknown(vec_mem[NUM_WORDS-1])) begin
      $display("stimulus file rvfi_stim_input.txt is missing or holds too few tests");
      load_err = 1'b1;
    end
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    check_reset_state();
    for (int unsigned idx = 0; idx < NUM_TESTS; idx++) begin
      run_test(fetch_test(idx));
    end
    $display("%0d tests run, %0d passed, %0d failed", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
    if ((fail_cnt == 0) && !load_err) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== rvfi_stim_input.txt ====
// code nxfer | xfer0 addr be we data prot | xfer1 addr be we data prot | all hex
// rvfi addr rmask wmask rdata wdata prot | trap | irq_ack | intr | expected err_o
01 1 00001000 F 0 11223344 7 00000000 0 0 00000000 0 00001000 F 0 11223344 00000000 7 00 0 0 00
02 1 00001004 F 1 CAFEBABE 7 00000000 0 0 00000000 0 00001004 0 F 00000000 CAFEBABE 7 00 0 0 00
03 1 00001002 4 0 775A9988 7 00000000 0 0 00000000 0 00001002 1 0 0000005A 00000000 7 00 0 0 00
04 1 00002002 C 1 BEEF1357 7 00000000 0 0 00000000 0 00002002 0 3 00000000 0000BEEF 7 00 0 0 00
05 2 00003003 8 0 CD112233 7 00003004 1 0 445566AB 7 00003003 3 0 0000ABCD 00000000 7 00 0 0 00
06 2 00003003 8 0 CD112233 7 00003004 1 0 445566AB 7 00003003 3 0 0000AACD 00000000 7 00 0 0 08
07 2 00004001 E 1 3322115E 7 00004004 1 1 99999944 7 00004001 0 F 00000000 44332211 7 00 0 0 00
08 1 00008001 6 0 AA1234BB 7 00000000 0 0 00000000 0 00008001 3 0 00001234 00000000 7 00 0 0 00
09 1 00005000 F 0 0BADF00D 7 00000000 0 0 00000000 0 00005004 F 0 0BADF00D 00000000 7 00 0 0 20
0A 1 00005100 F 0 1234BEEF 7 00000000 0 0 00000000 0 00005100 3 0 0000BEEF 00000000 7 00 0 0 10
0B 1 00005200 F 1 00C0FFEE 7 00000000 0 0 00000000 0 00005200 0 F 00000000 00C0FFEE 3 00 0 0 04
0C 0 00000000 0 0 00000000 0 00000000 0 0 00000000 0 00006000 F 0 00000000 00000000 7 00 0 0 02
0D 1 00006000 F 0 600DCAFE 7 00000000 0 0 00000000 0 00006000 F 0 600DCAFE 00000000 7 00 0 0 00
0E 0 00000000 0 0 00000000 0 00000000 0 0 00000000 0 00006101 0 F 00000000 12345678 7 00 0 0 02
0F 1 00007000 F 0 11111111 7 00000000 0 0 00000000 0 00007000 F 0 DEADDEAD 00000000 7 C5 0 0 00
10 1 00007100 F 1 01020304 7 00000000 0 0 00000000 0 00007100 0 F 00000000 04030201 7 C6 0 0 00
11 1 00007200 F 0 22222222 7 00000000 0 0 00000000 0 00007200 F 0 22222223 00000000 7 C2 0 0 08
12 1 00007300 F 0 33333333 7 00000000 0 0 00000000 0 00007300 F 0 3333333F 00000000 7 85 0 0 08
13 1 00009000 F 0 A5A5A5A5 7 00000000 0 0 00000000 0 00009000 F 0 A5A5A5A5 00000000 7 00 1 0 01
14 1 00009004 F 0 5A5A5A5A 7 00000000 0 0 00000000 0 00009004 F 0 5A5A5A5A 00000000 7 00 1 1 00
15 0 00000000 0 0 00000000 0 00000000 0 0 00000000 0 00000000 0 0 00000000 00000000 0 00 1 0 01
16 0 00000000 0 0 00000000 0 00000000 0 0 00000000 0 00000000 0 0 00000000 00000000 0 00 0 0 00
17 1 00009100 3 1 0000BEEF 7 00000000 0 0 00000000 0 00009100 0 3 00000000 0000BEEF 3 00 1 0 05

// ==== rvfi_mem_checker.f ====
rvfi_chk_pkg.sv
obi_xfer_fifo.sv
rvfi_mem_expect.sv
rvfi_mem_compare.sv
irq_ack_tracker.sv
rvfi_chk_ctrl.sv
rvfi_mem_checker.sv
tb_rvfi_mem_checker.sv
